// ==== rtl/rv_pkg.sv ====
// RV32I core shared definitions
`default_nettype none

package rv_pkg;

    // One instruction word, viewed as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;

    parameter logic [2:0] F3_ADD  = 3'b000;
    parameter logic [2:0] F3_SLL  = 3'b001;
    parameter logic [2:0] F3_SLT  = 3'b010;
    parameter logic [2:0] F3_SLTU = 3'b011;
    parameter logic [2:0] F3_XOR  = 3'b100;
    parameter logic [2:0] F3_SR   = 3'b101;
    parameter logic [2:0] F3_OR   = 3'b110;
    parameter logic [2:0] F3_AND  = 3'b111;

    // Upper bits for SUB and SRA, also upper immediate of SRAI
    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;

    // APB byte offsets
    parameter logic [11:0] REG_CTRL      = 12'h000;
    parameter logic [11:0] REG_STATUS    = 12'h004;
    parameter logic [11:0] REG_PROG_LEN  = 12'h008;
    parameter logic [11:0] REG_RETIRED   = 12'h00C;
    parameter logic [11:0] REG_RF_BASE   = 12'h100;
    parameter logic [11:0] REG_IMEM_BASE = 12'h400;

endpackage

`default_nettype wire

// ==== rtl/core_apb_regs.sv ====
// APB control and status block
`default_nettype none

module core_apb_regs #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [11:0]                   paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          start,
    output logic [$clog2(IMEM_DEPTH):0]   prog_len,
    input  logic                          busy,
    input  logic                          retire,
    output logic                          imem_we,
    output logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr,
    output logic [31:0]                   imem_wdata,
    output logic [4:0]                    dbg_addr,
    input  logic [31:0]                   dbg_data
);
    import rv_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    logic        access;
    logic        wr;
    logic        mapped;
    logic        refuse;
    logic        hit_ctrl;
    logic        hit_status;
    logic        hit_len;
    logic        hit_ret;
    logic        hit_rf;
    logic        hit_imem;
    logic [11:0] imem_off;
    logic        has_run;
    logic        done;
    logic [31:0] retired;

    assign access = psel & penable;
    assign pready = 1'b1;

    assign imem_off   = paddr - REG_IMEM_BASE;
    assign hit_ctrl   = (paddr == REG_CTRL);
    assign hit_status = (paddr == REG_STATUS);
    assign hit_len    = (paddr == REG_PROG_LEN);
    assign hit_ret    = (paddr == REG_RETIRED);
    assign hit_rf     = (paddr[11:7] == REG_RF_BASE[11:7]) && (paddr[1:0] == 2'b00);
    assign hit_imem   = (paddr >= REG_IMEM_BASE) && (imem_off[11:2] < IMEM_DEPTH)
                        && (paddr[1:0] == 2'b00);
    assign mapped     = hit_ctrl | hit_status | hit_len | hit_ret | hit_rf | hit_imem;

    // Writes refused while a program runs, or with an oversized length
    assign refuse = pwrite && ((hit_imem && busy) || (hit_ctrl && pwdata[0] && busy)
                    || (hit_len && pwdata > IMEM_DEPTH));

    assign pslverr = access & (~mapped | refuse);
    assign wr      = access & pwrite & mapped & ~refuse;

    assign imem_we    = wr & hit_imem;
    assign imem_waddr = imem_off[AW+1:2];
    assign imem_wdata = pwdata;
    assign dbg_addr   = paddr[6:2];

    assign done = has_run & ~busy & ~start;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_status) begin
                prdata = {30'd0, done, busy};
            end else if (hit_len) begin
                prdata = 32'(prog_len);
            end else if (hit_ret) begin
                prdata = retired;
            end else if (hit_rf) begin
                prdata = dbg_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start    <= 1'b0;
            prog_len <= '0;
            has_run  <= 1'b0;
            retired  <= '0;
        end else begin
            start <= wr & hit_ctrl & pwdata[0];
            if (wr && hit_len) begin
                prog_len <= pwdata[AW:0];
            end
            if (start) begin
                has_run <= 1'b1;
                retired <= '0;
            end else if (retire) begin
                retired <= retired + 32'd1;
            end
        end
    end

    // Run requests only reach the fetch stage while it is idle
    assert property (@(posedge clk) disable iff (reset) start |-> !busy);
    assert property (@(posedge clk) disable iff (reset)
                     pslverr |-> psel && penable && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== rtl/instr_mem.sv ====
// Instruction RAM
`default_nettype none

module instr_mem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] waddr,
    input  logic [31:0]                   wdata,
    input  logic [$clog2(IMEM_DEPTH)-1:0] raddr,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [IMEM_DEPTH];

    // Write from APB, read from fetch, both on the same edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// Fetch stage and run sequencer
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [$clog2(IMEM_DEPTH):0]   prog_len,
    input  logic [31:0]                   imem_rdata,
    output logic [$clog2(IMEM_DEPTH)-1:0] imem_raddr,
    output logic                          busy,
    output logic                          fetch_valid,
    output rv_pkg::instr_u                fetch_instr
);
    import rv_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [AW:0] pc;
    logic [AW:0] run_len;
    logic        issuing;
    logic        last_issue;
    logic [1:0]  drain;

    assign imem_raddr = pc[AW-1:0];
    assign last_issue = issuing && (pc + 1'b1 == run_len);

    // RAM output register acts as the fetch register
    assign fetch_instr = instr_u'(imem_rdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            run_len     <= '0;
            issuing     <= 1'b0;
            drain       <= 2'd0;
            busy        <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= issuing;
            if (start) begin
                pc      <= '0;
                run_len <= prog_len;
                issuing <= (prog_len != '0);
                busy    <= (prog_len != '0);
            end else if (issuing) begin
                pc <= pc + 1'b1;
                if (last_issue) begin
                    issuing <= 1'b0;
                    drain   <= 2'd2;
                end
            end else if (drain != 2'd0) begin
                // Decode and execute still hold work
                drain <= drain - 2'd1;
                if (drain == 2'd1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) issuing |-> pc < IMEM_DEPTH);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// Instruction decode and operand read
`default_nettype none

module decode_stage (
    input  logic           fetch_valid,
    input  rv_pkg::instr_u fetch_instr,
    output logic [4:0]     ra1,
    output logic [4:0]     ra2,
    input  logic [31:0]    rd1,
    input  logic [31:0]    rd2,
    exec_if.producer       ex
);
    import rv_pkg::*;

    logic [31:0] imm;
    logic        known;

    function automatic alu_op_e alu_select(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        op = ALU_ADD;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
        endcase
        return op;
    endfunction

    assign ra1 = fetch_instr.r.rs1;
    assign ra2 = fetch_instr.r.rs2;
    assign imm = {{20{fetch_instr.i.imm12[11]}}, fetch_instr.i.imm12};

    assign ex.dst  = fetch_instr.r.rd;
    assign ex.srca = rd1;

    always_comb begin
        known    = 1'b0;
        ex.aluop = ALU_ADD;
        ex.srcb  = rd2;
        case (fetch_instr.r.opcode)
            OPC_OP: begin
                // Only SUB and SRA may use the alternate funct7
                known = (fetch_instr.r.funct7 == F7_BASE)
                        || (fetch_instr.r.funct7 == F7_ALT
                            && (fetch_instr.r.funct3 == F3_ADD
                                || fetch_instr.r.funct3 == F3_SR));
                ex.aluop = alu_select(fetch_instr.r.funct3, fetch_instr.r.funct7 == F7_ALT);
            end
            OPC_OP_IMM: begin
                ex.srcb = imm;
                case (fetch_instr.i.funct3)
                    F3_SLL:  known = (fetch_instr.i.imm12[11:5] == F7_BASE);
                    F3_SR:   known = (fetch_instr.i.imm12[11:5] == F7_BASE)
                                     || (fetch_instr.i.imm12[11:5] == F7_ALT);
                    default: known = 1'b1;
                endcase
                // No SUBI, so the upper bits only select SRAI
                ex.aluop = alu_select(fetch_instr.i.funct3,
                                      fetch_instr.i.funct3 == F3_SR
                                      && fetch_instr.i.imm12[11:5] == F7_ALT);
            end
            default: begin
                known = 1'b0;
            end
        endcase
        ex.valid = fetch_valid & known;
        ex.wen   = known & (fetch_instr.r.rd != 5'd0);
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// Integer register file
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic        wen,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic [4:0]  dbg_addr,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] dbg_data
);

    logic [31:0] regs [1:31];

    // x0 reads zero; a register being written reads its new value
    function automatic logic [31:0] read_port(input logic [4:0] a);
        logic [31:0] value;
        value = '0;
        if (a != 5'd0) begin
            value = (wen && wa == a) ? wd : regs[a];
        end
        return value;
    endfunction

    always_comb begin
        rd1      = read_port(ra1);
        rd2      = read_port(ra2);
        dbg_data = read_port(dbg_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu_stage.sv ====
// Execute and write-back stage
`default_nettype none

module alu_stage (
    input  logic        clk,
    input  logic        reset,
    exec_if.consumer    ex,
    output logic        rf_wen,
    output logic [4:0]  rf_wa,
    output logic [31:0] rf_wd,
    output logic        retire
);
    import rv_pkg::*;

    logic        valid_q;
    logic        wen_q;
    alu_op_e     aluop_q;
    logic [4:0]  dst_q;
    logic [31:0] srca_q;
    logic [31:0] srcb_q;
    logic [4:0]  shamt;
    logic [31:0] result;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            valid_q <= ex.valid;
            wen_q   <= ex.wen;
        end
    end

    always_ff @(posedge clk) begin
        aluop_q <= ex.aluop;
        dst_q   <= ex.dst;
        srca_q  <= ex.srca;
        srcb_q  <= ex.srcb;
    end

    assign shamt = srcb_q[4:0];

    always_comb begin
        case (aluop_q)
            ALU_ADD:  result = srca_q + srcb_q;
            ALU_SUB:  result = srca_q - srcb_q;
            ALU_SLL:  result = srca_q << shamt;
            ALU_SLT:  result = {31'd0, $signed(srca_q) < $signed(srcb_q)};
            ALU_SLTU: result = {31'd0, srca_q < srcb_q};
            ALU_XOR:  result = srca_q ^ srcb_q;
            ALU_SRL:  result = srca_q >> shamt;
            ALU_SRA:  result = $unsigned($signed(srca_q) >>> shamt);
            ALU_OR:   result = srca_q | srcb_q;
            ALU_AND:  result = srca_q & srcb_q;
            default:  result = '0;
        endcase
    end

    // Writes to x0 still retire but leave the file alone
    assign rf_wen = valid_q & wen_q;
    assign rf_wa  = dst_q;
    assign rf_wd  = result;
    assign retire = valid_q;

    assert property (@(posedge clk) disable iff (reset) rf_wen |-> retire && rf_wa != 5'd0);

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
// RV32I core top level
`default_nettype none

interface exec_if;
    import rv_pkg::*;

    logic        valid;
    alu_op_e     aluop;
    logic [4:0]  dst;
    logic [31:0] srca;
    logic [31:0] srcb;
    logic        wen;

    modport producer (output valid, aluop, dst, srca, srcb, wen);
    modport consumer (input valid, aluop, dst, srca, srcb, wen);
endinterface

module rv_core_top #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import rv_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    logic          start;
    logic          busy;
    logic          retire;
    logic [AW:0]   prog_len;
    logic          imem_we;
    logic [AW-1:0] imem_waddr;
    logic [AW-1:0] imem_raddr;
    logic [31:0]   imem_wdata;
    logic [31:0]   imem_rdata;
    logic [4:0]    dbg_addr;
    logic [31:0]   dbg_data;
    logic          fetch_valid;
    instr_u        fetch_instr;
    logic [4:0]    ra1;
    logic [4:0]    ra2;
    logic [31:0]   rd1;
    logic [31:0]   rd2;
    logic          rf_wen;
    logic [4:0]    rf_wa;
    logic [31:0]   rf_wd;

    exec_if ex0 ();

    core_apb_regs #(.IMEM_DEPTH(IMEM_DEPTH)) apb0 (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .prog_len(prog_len), .busy(busy), .retire(retire),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) imem0 (
        .clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
        .raddr(imem_raddr), .rdata(imem_rdata)
    );

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
        .clk(clk), .reset(reset), .start(start), .prog_len(prog_len),
        .imem_rdata(imem_rdata), .imem_raddr(imem_raddr), .busy(busy),
        .fetch_valid(fetch_valid), .fetch_instr(fetch_instr)
    );

    decode_stage decode0 (
        .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2), .ex(ex0.producer)
    );

    regfile rf0 (
        .clk(clk), .reset(reset), .ra1(ra1), .ra2(ra2),
        .wen(rf_wen), .wa(rf_wa), .wd(rf_wd), .dbg_addr(dbg_addr),
        .rd1(rd1), .rd2(rd2), .dbg_data(dbg_data)
    );

    alu_stage alu0 (
        .clk(clk), .reset(reset), .ex(ex0.consumer),
        .rf_wen(rf_wen), .rf_wa(rf_wa), .rf_wd(rf_wd), .retire(retire)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
// Testbench for the RV32I core
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int          DEPTH      = 256;
    localparam int          CASE_WORDS = 1024;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

    logic        clk;
    logic        reset;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] cases [CASE_WORDS];
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;

    rv_core_top #(.IMEM_DEPTH(DEPTH)) dut0 (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #5 clk = ~clk;

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error: %s read %h, expected %h", name, got, expected);
        end
    endtask

    task automatic apb_access(input logic [11:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (pready !== 1'b1) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(addr, 1'b0, 32'd0, data, err);
    endtask

    task automatic write_check(input logic [11:0] addr, input logic [31:0] data,
                               input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        check_value("pslverr", 32'(err), 32'(exp_err));
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] expected,
                              input string name);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value("pslverr", 32'(err), 32'd0);
        check_value(name, data, expected);
    endtask

    // Polls STATUS until the done bit shows
    task automatic wait_done();
        logic [31:0] status;
        logic        err;
        status = '0;
        while (status[1] !== 1'b1) begin
            apb_read(REG_STATUS, status, err);
        end
    endtask

    task automatic run_case(input int base, output int next);
        int len;
        int ptr;
        int pairs;
        len = cases[base];
        ptr = base + 1;
        for (int i = 0; i < len; i++) begin
            write_check(REG_IMEM_BASE + 12'(4 * i), cases[ptr + i], 1'b0);
        end
        ptr = ptr + len;
        write_check(REG_PROG_LEN, 32'(len), 1'b0);
        write_check(REG_CTRL, 32'd1, 1'b0);
        // Refused while the program runs
        write_check(REG_IMEM_BASE + 12'(4 * (len - 1)), NOP_WORD, 1'b1);
        write_check(REG_CTRL, 32'd1, 1'b1);
        wait_done();
        read_check(REG_STATUS, 32'h2, "STATUS");
        read_check(REG_RETIRED, cases[ptr], "RETIRED");
        pairs = cases[ptr + 1];
        ptr = ptr + 2;
        for (int i = 0; i < pairs; i++) begin
            read_check(REG_RF_BASE + 12'(4 * cases[ptr]), cases[ptr + 1],
                       $sformatf("x%0d", cases[ptr]));
            ptr = ptr + 2;
        end
        next = ptr;
    endtask

    initial begin
        int          ptr;
        int          total;
        int          ncases;
        logic [31:0] data;
        logic        err;
        clk     = 1'b0;
        reset   <= 1'b1;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;

        $readmemh("testbench/rv_core_cases.txt", cases);
        total  = 0;
        ncases = 0;
        ptr    = 0;
        while (ptr < CASE_WORDS - 2 && cases[ptr] != 0 && !$isunknown(cases[ptr])) begin
            total  = total + cases[ptr];
            ncases = ncases + 1;
            ptr    = ptr + cases[ptr] + 1;
            ptr    = ptr + 2 + 2 * cases[ptr + 1];
        end
        cycle_limit = total * 8 + 2000;
        if (ncases == 0) begin
            errors++;
            $display("No programs could be read from the cases file");
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Idle state after reset
        read_check(REG_STATUS, 32'd0, "STATUS");
        read_check(REG_RETIRED, 32'd0, "RETIRED");
        for (int i = 0; i < 32; i++) begin
            read_check(REG_RF_BASE + 12'(4 * i), 32'd0, $sformatf("x%0d", i));
        end
        apb_read(12'h010, data, err);
        check_value("pslverr", 32'(err), 32'd1);
        write_check(REG_PROG_LEN, 32'(DEPTH + 1), 1'b1);
        read_check(REG_PROG_LEN, 32'd0, "PROG_LEN");

        // Programs run back to back, registers carry over
        ptr = 0;
        for (int c = 0; c < ncases; c++) begin
            run_case(ptr, ptr);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_core_cases.txt ====
// Per case: program length, instruction words, expected RETIRED, pair count,
// then register index and expected value pairs; a zero length ends the list
// Immediate forms on a cleared register file
00000009
FFB00093 FFC0A113 0050B193 0F00C213 55506293
7F00F313 01429393 0040D413 4010D493
00000009 00000009
01 FFFFFFFB 02 00000001 03 00000000 04 FFFFFF0B 05 00000555
06 000007F0 07 55500000 08 0FFFFFFF 09 FFFFFFFD
// All ten register forms on values left by the first run
0000000A
00508533 405105B3 00229633 0020A6B3 0020B733
0050C7B3 0020D833 4020D8B3 0050E933 0050F9B3
0000000A 0000000A
0A 00000550 0B FFFFFAAC 0C 00000AAA 0D 00000001 0E 00000000
0F FFFFFAAE 10 7FFFFFFD 11 FFFFFFFD 12 FFFFFFFF 13 00000551
// Dependent chain, with two writes to x0
0000000A
00100A13 014A0A33 014A0A33 003A0A93 004A9A93
005A8013 015A8033 400A8B33 014B4B33 000B6BB3
0000000A 00000005
00 00000000 14 00000004 15 00000070 16 00000074 17 00000074
// Reuses earlier results, the JAL word is a bubble
00000006
01750C33 0000006F 40C98CB3 015CDD33 FFF4BD93 4045DE13
00000005 00000007
18 000005C4 19 FFFFFAA7 1A 0000FFFF 1B 00000001 1C FFFFFFAA
01 FFFFFFFB 14 00000004
00000000

// ==== build.f ====
rtl/rv_pkg.sv
rtl/core_apb_regs.sv
rtl/instr_mem.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/alu_stage.sv
rtl/rv_core_top.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f build.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)

run: compile
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
